//--- flist.f
src/ctrlPkg.sv
src/instrDecode.sv
src/stageSequencer.sv
src/controlWordGen.sv
src/stage1Ctrl.sv
sim/tbClock.sv
sim/stage1CtrlTb.sv

//--- sim/stage1CtrlTb.sv
`timescale 1ns/1ps

module stage1CtrlTb
	import ctrlPkg::*;
;

	logic       clk;
	logic       reset;
	logic [7:0] instr;
	logic [7:0] irData;
	logic [7:0] mdrData;
	logic       stg0State;
	ctrlWordT   ctrl;
	shiftCountT numShift;
	logic       stg1State;
	stateT      state;

	stateT      modelState;
	stateT      modelNext;
	logic       modelStg1;
	shiftCountT modelShift;
	logic       visited [0:127]; // States seen in the current instruction
	int         checkCount;
	int         errorCount;
	int         testErrors;
	opcodeT     aluOps [5];
	logic [7:0] ir;
	logic [7:0] mdr;
	stateT      firstStep;
	stateT      lastStep;

	tbClock clockGen (
		.clk   (clk),
		.reset (reset)
	);

	stage1Ctrl UUT (
		.clk       (clk),
		.reset     (reset),
		.instr     (instr),
		.irData    (irData),
		.mdrData   (mdrData),
		.stg0State (stg0State),
		.ctrl      (ctrl),
		.numShift  (numShift),
		.stg1State (stg1State),
		.state     (state)
	);

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic stateT nextStateOf(stateT s, logic [7:0] ins, logic [7:0] mdm, logic go);
		instrWordT w;
		logic      isAlu;
		stateT     n;
		w = ins;
		isAlu = w.addr.opcode inside {opAdd, opSub, opOr, opAnd, opLoad};
		n = Idle;
		case (s)
			Idle:     n = go ? Dispatch : Idle;
			Dispatch: begin
				if (!go)
					n = Dispatch;
				else if (w.addr.opcode == opShift)
					n = FetchDirect;
				else if (w.addr.opcode == opNop)
					n = NopState;
				else if (w.addr.opcode == opMulDiv)
					n = w.mulDiv.spare ? Idle : (w.mulDiv.isIndirect ? IndirectA : FetchDirect);
				else if (isAlu || w.addr.opcode == opStore) begin
					if (w.addr.mode == modeDirect)
						n = FetchDirect;
					else if (w.addr.mode == modeIndirect)
						n = IndirectA;
					else if (w.addr.mode == modeImmediate && isAlu)
						n = FetchImm;
				end
			end
			FetchDirect: n = (w.addr.opcode == opShift) ? OpSelect : AddrOut;
			AddrOut:     n = MemRead;
			MemRead:     n = (w.addr.opcode == opStore) ? StoreA : Execute;
			Execute: begin
				case (w.addr.opcode)
					opAdd:    n = AddDirect;
					opSub:    n = SubDirect;
					opOr:     n = OrDirect;
					opAnd:    n = AndDirect;
					opLoad:   n = LoadDirect;
					opMulDiv: n = OpSelect;
					default:  n = Idle;
				endcase
			end
			FetchImm: begin
				case (w.addr.opcode)
					opAdd:   n = AddImm;
					opSub:   n = SubImm;
					opOr:    n = OrImm;
					opAnd:   n = AndImm;
					opLoad:  n = LoadImm;
					default: n = Idle;
				endcase
			end
			IndirectA, IndirectB, IndirectC, IndirectD: n = stateT'(s + 1);
			IndirectE: n = MemRead;
			OpSelect: begin
				if (w.addr.opcode == opMulDiv)
					n = MulDivStart;
				else if (w.addr.opcode == opShift && w.addr.mode < 3'd4)
					n = stateT'(7'd57 + w.addr.mode); // Shift kind order 57 to 60
			end
			MulDivStart: begin
				if (w.mulDiv.isDiv)
					n = mdm[0] ? DivOddA : DivEvenA;
				else
					n = mdm[0] ? MulOddA : MulEvenA;
			end
			MulEvenA: n = MulEvenB;
			MulOddA:  n = MulOddB;
			MulOddB:  n = MulOddC;
			MulOddC:  n = MulOddD;
			DivEvenA: n = DivEvenB;
			DivOddA:  n = DivOddB;
			DivOddB:  n = DivOddC;
			DivOddC:  n = DivOddD;
			ShiftL0, ShiftL1, ShiftR0, ShiftR1: n = stateT'(s - 29); // Results 28 to 31
			StoreA:   n = StoreB;
			default:  n = Idle;
		endcase
		return n;
	endfunction

	function automatic ctrlWordT controlWordOf(stateT s);
		case (s)
			FetchDirect, IndirectA, FetchImm: return 35'b10000000000000011110001110110000001;
			AddrOut, IndirectB, IndirectE:    return 35'b10000000000010010101001110110000001;
			MemRead, IndirectC:               return 35'b10000000000010010100001110110000001;
			Execute, IndirectD:               return 35'b10000000000010010100101110110000001;
			AddDirect:  return 35'b10100000000000010100001110110000001;
			AddImm:     return 35'b10100000000000010100001111110000001;
			SubDirect:  return 35'b10100110000000010100001110110000001;
			SubImm:     return 35'b10100110000000010100001111110000001;
			OrDirect:   return 35'b10101000000000010100001110110000001;
			OrImm:      return 35'b10101000000000010100001111110000001;
			AndDirect:  return 35'b10110000000000010100001110110000001;
			AndImm:     return 35'b10110000000000010100001111110000001;
			LoadDirect: return 35'b10100000000000010100000110110000001;
			LoadImm:    return 35'b10100000000000010100001010110000001;
			MulDivStart, OpSelect:      return 35'b10000000000000010100001110110001001;
			MulEvenA, MulOddB, ShiftL0: return 35'b10000000000000010100000010110010001;
			MulEvenB, MulOddC, DivEvenB, DivOddC, ShiftResL0, ShiftResL1, ShiftResR0, ShiftResR1:
				return 35'b10100000000000010100000010110000001;
			MulOddA, DivOddA: return 35'b10000000010100010100001110110000001;
			MulOddD, DivOddD: return 35'b10100000000000010100001100110000001;
			DivEvenA, DivOddB: return 35'b10000000000000010100000010110011001;
			ShiftL1:  return 35'b10100000000000010100000010110010101;
			ShiftR0:  return 35'b10100000000000010100000010110011001;
			ShiftR1:  return 35'b10100000000000010100000010110011011;
			StoreA:   return 35'b10000000000010010100101110101100001;
			StoreB:   return 35'b10000000000011010100001110110000001;
			NopState: return 35'b10000000000000010100001110110000001;
			default:  return 35'b10000000000000011100001110110000001; // Idle and Dispatch
		endcase
	endfunction

	task automatic checkValue(string name, logic [63:0] actual, logic [63:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	//////////////////////////////////////////////////
	// Comparing process sampling before the edge updates
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset) begin
			modelState = Idle;
			modelStg1 = 1'b0;
			modelShift = '0;
		end else begin
			checkValue("state", state, modelState);
			checkValue("ctrl", ctrl, controlWordOf(modelState));
			checkValue("stg1State", stg1State, modelStg1);
			checkValue("numShift", numShift, modelShift);
			visited[state] = 1'b1;
			modelNext = nextStateOf(modelState, instr, mdrData, stg0State);
			if (modelState inside {ShiftL0, ShiftL1, ShiftR0, ShiftR1})
				modelShift = irData[2:0];
			else if (modelState inside {MulEvenA, MulEvenB, MulOddA, MulOddB, MulOddC, MulOddD,
					DivEvenA, DivEvenB, DivOddA, DivOddB, DivOddC, DivOddD})
				modelShift = mdrData[2:0] >> 1;
			if (modelNext == Dispatch)
				modelStg1 = 1'b1;
			else if (modelNext inside {FetchDirect, IndirectA, FetchImm, NopState})
				modelStg1 = 1'b0;
			modelState = modelNext;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic waitForState(stateT target, int limit, string what);
		int i;
		i = 0;
		while (state !== target && i < limit) begin
			@(negedge clk);
			i++;
		end
		if (state !== target) begin
			errorCount++;
			$display("Timeout: state never reached %s while waiting for %s", target.name(), what);
			$display("CHECKS FAILED");
			$finish;
		end
	endtask

	// Takes one instruction from Idle back to Idle
	task automatic runInstruction(logic [7:0] ins, logic [7:0] irValue, logic [7:0] mdrValue);
		int bubbles;
		bubbles = $urandom_range(3, 0);
		foreach (visited[k])
			visited[k] = 1'b0;
		instr = ins;
		irData = irValue;
		mdrData = mdrValue;
		stg0State = 1'b1;
		@(negedge clk);
		waitForState(Dispatch, 8, "dispatch");
		stg0State = 1'b0; // Stage 0 bubbles
		repeat (bubbles) @(negedge clk);
		stg0State = 1'b1;
		@(negedge clk);
		stg0State = 1'b0;
		waitForState(Idle, 40, "end of instruction");
	endtask

	task automatic reportTest(string name);
		$display("Test %s: %s", name, (errorCount == testErrors) ? "ok" : "mismatch");
		testErrors = errorCount;
	endtask

	initial begin
		instr = 8'h00;
		irData = 8'h00;
		mdrData = 8'h00;
		stg0State = 1'b0;
		checkCount = 0;
		errorCount = 0;
		testErrors = 0;
		aluOps = '{opAdd, opSub, opOr, opAnd, opLoad};
		void'($urandom(32'h9a504805));

		waitForState(Idle, 20, "reset");
		for (int i = 0; i < 20 && reset; i++)
			@(negedge clk);
		@(negedge clk);
		checkValue("state", state, Idle);
		checkValue("stg1State", stg1State, 1'b0);
		checkValue("numShift", numShift, 3'd0);
		checkValue("ctrl", ctrl, 35'b10000000000000011100001110110000001);
		reportTest("reset values");

		foreach (aluOps[i])
			for (int m = 0; m < 3; m++)
				runInstruction({aluOps[i], 3'(m)}, 8'($urandom), 8'($urandom));
		reportTest("ALU and load, three modes");

		for (int m = 0; m < 2; m++) begin
			runInstruction({opStore, 3'(m)}, 8'($urandom), 8'($urandom));
			checkValue("path StoreA", visited[StoreA], 1'b1);
			checkValue("path StoreB", visited[StoreB], 1'b1);
		end
		runInstruction({opNop, 3'b000}, 8'($urandom), 8'($urandom));
		checkValue("path NopState", visited[NopState], 1'b1);
		reportTest("store and NOP");

		for (int k = 0; k < 4; k++) begin
			ir = 8'($urandom);
			runInstruction({opShift, 3'(k)}, ir, 8'($urandom));
			checkValue("path shift state", visited[7'd57 + k], 1'b1);
			checkValue("numShift after shift", numShift, ir[2:0]);
		end
		reportTest("shift kinds");

		for (int k = 0; k < 8; k++) begin
			mdr = (8'($urandom) & 8'hFE) | 8'(k[0]);
			if (k[1])
				firstStep = k[0] ? DivOddA : DivEvenA;
			else
				firstStep = k[0] ? MulOddA : MulEvenA;
			if (k[1])
				lastStep = k[0] ? DivOddD : DivEvenB;
			else
				lastStep = k[0] ? MulOddD : MulEvenB;
			runInstruction({opMulDiv, 1'b0, k[1], k[2]}, 8'($urandom), mdr);
			checkValue("path first step", visited[firstStep], 1'b1);
			checkValue("path last step", visited[lastStep], 1'b1);
			checkValue("numShift after mul/div", numShift, mdr[2:0] >> 1);
		end
		reportTest("multiply and divide");

		stg0State = 1'b0;
		repeat (6) @(negedge clk);
		checkValue("state held in Idle", state, Idle);
		stg0State = 1'b1;
		@(negedge clk);
		stg0State = 1'b0;
		repeat (6) @(negedge clk);
		checkValue("state held in Dispatch", state, Dispatch);
		instr = 8'hF8; // Opcode outside the set
		stg0State = 1'b1;
		@(negedge clk);
		stg0State = 1'b0;
		checkValue("state after bad opcode", state, Idle);
		runInstruction({opStore, modeImmediate}, 8'($urandom), 8'($urandom));
		reportTest("stalls and unsupported opcodes");

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- sim/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// Held over three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- src/stage1Ctrl.sv
`timescale 1ns/1ps

module stage1Ctrl
	import ctrlPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] instr,
	input  logic [7:0] irData,
	input  logic [7:0] mdrData,
	input  logic       stg0State,
	output ctrlWordT   ctrl,
	output shiftCountT numShift,
	output logic       stg1State,
	output stateT      state
);

	// Successor of each branching state
	stateT dispatchNext;
	stateT fetchNext;
	stateT memNext;
	stateT execNext;
	stateT immNext;
	stateT selectNext;
	stateT mulDivNext;

	instrDecode decoder (
		.instr        (instr),
		.mdrData      (mdrData),
		.state        (state),
		.dispatchNext (dispatchNext),
		.fetchNext    (fetchNext),
		.memNext      (memNext),
		.execNext     (execNext),
		.immNext      (immNext),
		.selectNext   (selectNext),
		.mulDivNext   (mulDivNext)
	);

	stageSequencer sequencer (
		.clk          (clk),
		.reset        (reset),
		.stg0State    (stg0State),
		.dispatchNext (dispatchNext),
		.fetchNext    (fetchNext),
		.memNext      (memNext),
		.execNext     (execNext),
		.immNext      (immNext),
		.selectNext   (selectNext),
		.mulDivNext   (mulDivNext),
		.state        (state),
		.stg1State    (stg1State)
	);

	controlWordGen wordGen (
		.clk      (clk),
		.reset    (reset),
		.state    (state),
		.irData   (irData),
		.mdrData  (mdrData),
		.ctrl     (ctrl),
		.numShift (numShift)
	);

endmodule

//--- src/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen
	import ctrlPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  stateT      state,
	input  logic [7:0] irData,
	input  logic [7:0] mdrData,
	output ctrlWordT   ctrl,
	output shiftCountT numShift
);

	localparam ctrlWordT IdleWord = 35'b10000000000000011100001110110000001;

	//////////////////////////////////////////////////
	// Control word table
	//////////////////////////////////////////////////

	always_comb begin
		case (state)
			Idle:        ctrl = IdleWord;
			Dispatch:    ctrl = 35'b10000000000000011100001110110000001;

			// Operand fetch
			FetchDirect: ctrl = 35'b10000000000000011110001110110000001;
			AddrOut:     ctrl = 35'b10000000000010010101001110110000001;
			MemRead:     ctrl = 35'b10000000000010010100001110110000001;
			Execute:     ctrl = 35'b10000000000010010100101110110000001;
			IndirectA:   ctrl = 35'b10000000000000011110001110110000001;
			IndirectB:   ctrl = 35'b10000000000010010101001110110000001;
			IndirectC:   ctrl = 35'b10000000000010010100001110110000001;
			IndirectD:   ctrl = 35'b10000000000010010100101110110000001;
			IndirectE:   ctrl = 35'b10000000000010010101001110110000001;
			FetchImm:    ctrl = 35'b10000000000000011110001110110000001;

			// ALU and load results
			AddDirect:   ctrl = 35'b10100000000000010100001110110000001;
			AddImm:      ctrl = 35'b10100000000000010100001111110000001;
			SubDirect:   ctrl = 35'b10100110000000010100001110110000001;
			SubImm:      ctrl = 35'b10100110000000010100001111110000001;
			OrDirect:    ctrl = 35'b10101000000000010100001110110000001;
			OrImm:       ctrl = 35'b10101000000000010100001111110000001;
			AndDirect:   ctrl = 35'b10110000000000010100001110110000001;
			AndImm:      ctrl = 35'b10110000000000010100001111110000001;
			LoadDirect:  ctrl = 35'b10100000000000010100000110110000001;
			LoadImm:     ctrl = 35'b10100000000000010100001010110000001;

			// Multiply and divide
			MulDivStart: ctrl = 35'b10000000000000010100001110110001001;
			MulEvenA:    ctrl = 35'b10000000000000010100000010110010001;
			MulEvenB:    ctrl = 35'b10100000000000010100000010110000001;
			MulOddA:     ctrl = 35'b10000000010100010100001110110000001;
			MulOddB:     ctrl = 35'b10000000000000010100000010110010001;
			MulOddC:     ctrl = 35'b10100000000000010100000010110000001;
			MulOddD:     ctrl = 35'b10100000000000010100001100110000001;
			DivEvenA:    ctrl = 35'b10000000000000010100000010110011001;
			DivEvenB:    ctrl = 35'b10100000000000010100000010110000001;
			DivOddA:     ctrl = 35'b10000000010100010100001110110000001;
			DivOddB:     ctrl = 35'b10000000000000010100000010110011001;
			DivOddC:     ctrl = 35'b10100000000000010100000010110000001;
			DivOddD:     ctrl = 35'b10100000000000010100001100110000001;

			// Shifter
			OpSelect:    ctrl = 35'b10000000000000010100001110110001001;
			ShiftL0:     ctrl = 35'b10000000000000010100000010110010001;
			ShiftL1:     ctrl = 35'b10100000000000010100000010110010101;
			ShiftR0:     ctrl = 35'b10100000000000010100000010110011001;
			ShiftR1:     ctrl = 35'b10100000000000010100000010110011011;
			ShiftResL0:  ctrl = 35'b10100000000000010100000010110000001;
			ShiftResL1:  ctrl = 35'b10100000000000010100000010110000001;
			ShiftResR0:  ctrl = 35'b10100000000000010100000010110000001;
			ShiftResR1:  ctrl = 35'b10100000000000010100000010110000001;

			// Store and NOP
			StoreA:      ctrl = 35'b10000000000010010100101110101100001;
			StoreB:      ctrl = 35'b10000000000011010100001110110000001;
			NopState:    ctrl = 35'b10000000000000010100001110110000001;

			default:     ctrl = IdleWord;
		endcase
	end

	//////////////////////////////////////////////////
	// Shift count
	//////////////////////////////////////////////////

	// Sampled on the edge after the step is entered
	always_ff @(posedge clk) begin
		if (reset) begin
			numShift <= '0;
		end else if (state inside {ShiftL0, ShiftL1, ShiftR0, ShiftR1}) begin
			numShift <= irData[2:0];
		end else if (state inside {MulEvenA, MulEvenB, MulOddA, MulOddB, MulOddC, MulOddD,
				DivEvenA, DivEvenB, DivOddA, DivOddB, DivOddC, DivOddD}) begin
			numShift <= mdrData[2:0] >> 1; // Half of low data bits
		end
	end

endmodule

//--- src/stageSequencer.sv
`timescale 1ns/1ps

module stageSequencer
	import ctrlPkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  stg0State,
	input  stateT dispatchNext,
	input  stateT fetchNext,
	input  stateT memNext,
	input  stateT execNext,
	input  stateT immNext,
	input  stateT selectNext,
	input  stateT mulDivNext,
	output stateT state,
	output logic  stg1State
);

	stateT nextState;

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb begin
		case (state)
			Idle: begin
				if (stg0State)
					nextState = Dispatch;
				else
					nextState = Idle;
			end
			Dispatch: begin
				if (stg0State)
					nextState = dispatchNext;
				else
					nextState = Dispatch; // Bubble until stage 0 is ready
			end

			// Direct operand path
			FetchDirect: nextState = fetchNext;
			AddrOut:     nextState = MemRead;
			MemRead:     nextState = memNext;
			Execute:     nextState = execNext;
			FetchImm:    nextState = immNext;

			// Indirect address chain
			IndirectA: nextState = IndirectB;
			IndirectB: nextState = IndirectC;
			IndirectC: nextState = IndirectD;
			IndirectD: nextState = IndirectE;
			IndirectE: nextState = MemRead;

			OpSelect:    nextState = selectNext;
			MulDivStart: nextState = mulDivNext;

			// Multiply steps
			MulEvenA: nextState = MulEvenB;
			MulOddA:  nextState = MulOddB;
			MulOddB:  nextState = MulOddC;
			MulOddC:  nextState = MulOddD;

			// Divide steps
			DivEvenA: nextState = DivEvenB;
			DivOddA:  nextState = DivOddB;
			DivOddB:  nextState = DivOddC;
			DivOddC:  nextState = DivOddD;

			// Shifter
			ShiftL0: nextState = ShiftResL0;
			ShiftL1: nextState = ShiftResL1;
			ShiftR0: nextState = ShiftResR0;
			ShiftR1: nextState = ShiftResR1;

			StoreA: nextState = StoreB;

			default: nextState = Idle; // Results, last steps, StoreB, NOP
		endcase
	end

	//////////////////////////////////////////////////
	// State register and stage-0 status
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stg1State <= 1'b0;
		end else if (nextState == Dispatch) begin
			stg1State <= 1'b1; // Instruction about to be taken
		end else if (nextState inside {FetchDirect, IndirectA, FetchImm, NopState}) begin
			stg1State <= 1'b0;
		end
	end

endmodule

//--- src/instrDecode.sv
`timescale 1ns/1ps

module instrDecode
	import ctrlPkg::*;
(
	input  logic [7:0] instr,
	input  logic [7:0] mdrData,
	input  stateT      state,
	output stateT      dispatchNext,
	output stateT      fetchNext,
	output stateT      memNext,
	output stateT      execNext,
	output stateT      immNext,
	output stateT      selectNext,
	output stateT      mulDivNext
);

	instrWordT instrWord;

	assign instrWord = instr;

	//////////////////////////////////////////////////
	// Dispatch, opcode and operand mode
	//////////////////////////////////////////////////

	always_comb begin
		dispatchNext = Idle;
		if (state == Dispatch) begin
			case (instrWord.addr.opcode)
				opAdd, opSub, opOr, opAnd, opLoad: begin
					case (instrWord.addr.mode)
						modeDirect:    dispatchNext = FetchDirect;
						modeIndirect:  dispatchNext = IndirectA;
						modeImmediate: dispatchNext = FetchImm;
						default:       dispatchNext = Idle;
					endcase
				end
				opStore: begin
					case (instrWord.addr.mode)
						modeDirect:   dispatchNext = FetchDirect;
						modeIndirect: dispatchNext = IndirectA;
						default:      dispatchNext = Idle; // No immediate store
					endcase
				end
				opMulDiv: begin
					if (instrWord.mulDiv.spare)
						dispatchNext = Idle;
					else if (instrWord.mulDiv.isIndirect)
						dispatchNext = IndirectA;
					else
						dispatchNext = FetchDirect;
				end
				opShift: dispatchNext = FetchDirect;
				opNop:   dispatchNext = NopState;
				default: dispatchNext = Idle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Fetch and execute branches
	//////////////////////////////////////////////////

	assign fetchNext = (instrWord.addr.opcode == opShift) ? OpSelect : AddrOut;
	assign memNext = (instrWord.addr.opcode == opStore) ? StoreA : Execute;

	always_comb begin
		case (instrWord.addr.opcode)
			opAdd:    execNext = AddDirect;
			opSub:    execNext = SubDirect;
			opOr:     execNext = OrDirect;
			opAnd:    execNext = AndDirect;
			opLoad:   execNext = LoadDirect;
			opMulDiv: execNext = OpSelect;
			default:  execNext = Idle;
		endcase
	end

	always_comb begin
		case (instrWord.addr.opcode)
			opAdd:   immNext = AddImm;
			opSub:   immNext = SubImm;
			opOr:    immNext = OrImm;
			opAnd:   immNext = AndImm;
			opLoad:  immNext = LoadImm;
			default: immNext = Idle;
		endcase
	end

	always_comb begin
		selectNext = Idle;
		if (instrWord.addr.opcode == opMulDiv) begin
			selectNext = MulDivStart;
		end else if (instrWord.addr.opcode == opShift) begin
			case (instrWord.addr.mode) // Low bits carry the shift kind here
				shiftLeft0:  selectNext = ShiftL0;
				shiftLeft1:  selectNext = ShiftL1;
				shiftRight0: selectNext = ShiftR0;
				shiftRight1: selectNext = ShiftR1;
				default:     selectNext = Idle;
			endcase
		end
	end

	// Parity of memory data picks the short or long sequence
	always_comb begin
		if (instrWord.mulDiv.isDiv)
			mulDivNext = mdrData[0] ? DivOddA : DivEvenA;
		else
			mulDivNext = mdrData[0] ? MulOddA : MulEvenA;
	end

endmodule

//--- src/ctrlPkg.sv
package ctrlPkg;

	//////////////////////////////////////////////////
	// Instruction fields
	//////////////////////////////////////////////////

	typedef enum logic [4:0] {
		opAdd    = 5'b00000,
		opSub    = 5'b00001,
		opMulDiv = 5'b00010,
		opOr     = 5'b00011,
		opAnd    = 5'b00100,
		opShift  = 5'b00101,
		opLoad   = 5'b01010,
		opStore  = 5'b01011,
		opNop    = 5'b01111
	} opcodeT;

	typedef enum logic [2:0] {
		modeDirect    = 3'b000,
		modeIndirect  = 3'b001,
		modeImmediate = 3'b010
	} modeT;

	typedef enum logic [2:0] {
		shiftLeft0  = 3'b000,
		shiftLeft1  = 3'b001,
		shiftRight0 = 3'b010,
		shiftRight1 = 3'b011
	} shiftKindT;

	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] mode; // Mode or shift kind for SHFT
	} addrViewT;

	typedef struct packed {
		opcodeT opcode;
		logic   spare;
		logic   isDiv;
		logic   isIndirect;
	} mulDivViewT;

	typedef union packed {
		addrViewT   addr;
		mulDivViewT mulDiv;
	} instrWordT;

	//////////////////////////////////////////////////
	// Controller states numbered as timing states
	//////////////////////////////////////////////////

	typedef enum logic [6:0] {
		FetchDirect = 7'd0,
		AddrOut     = 7'd1,
		MemRead     = 7'd2,
		Execute     = 7'd3,
		IndirectA   = 7'd4,
		IndirectB   = 7'd5,
		IndirectC   = 7'd6,
		IndirectD   = 7'd7,
		IndirectE   = 7'd8,
		FetchImm    = 7'd9,
		AddDirect   = 7'd10,
		AddImm      = 7'd11,
		SubDirect   = 7'd12,
		SubImm      = 7'd13,
		OrDirect    = 7'd14,
		OrImm       = 7'd15,
		AndDirect   = 7'd16,
		AndImm      = 7'd17,
		MulDivStart = 7'd19,
		MulEvenB    = 7'd20,
		MulOddA     = 7'd21,
		MulOddC     = 7'd22,
		MulOddD     = 7'd23,
		DivEvenB    = 7'd24,
		DivOddA     = 7'd25,
		DivOddC     = 7'd26,
		DivOddD     = 7'd27,
		ShiftResL0  = 7'd28,
		ShiftResL1  = 7'd29,
		ShiftResR0  = 7'd30,
		ShiftResR1  = 7'd31,
		LoadDirect  = 7'd32,
		LoadImm     = 7'd33,
		StoreA      = 7'd34,
		StoreB      = 7'd35,
		NopState    = 7'd50,
		OpSelect    = 7'd54,
		Idle        = 7'd55,
		Dispatch    = 7'd56,
		ShiftL0     = 7'd57,
		ShiftL1     = 7'd58,
		ShiftR0     = 7'd59,
		ShiftR1     = 7'd60,
		MulEvenA    = 7'd61,
		MulOddB     = 7'd62,
		DivEvenA    = 7'd63,
		DivOddB     = 7'd64
	} stateT;

	typedef logic [34:0] ctrlWordT; // Datapath control and select points

	typedef logic [2:0] shiftCountT;

endpackage
